//--- verilog.f
source/merge_pkg.sv
source/merge_loader.sv
source/merge_stage.sv
source/merge_collector.sv
source/bitonic_merger_top.sv
sim/merger_assertions.sv
sim/tb_bitonic_merger.sv

//--- Bender.yml
package:
  name: bitonic_merger

sources:
  - source/merge_pkg.sv
  - source/merge_loader.sv
  - source/merge_stage.sv
  - source/merge_collector.sv
  - source/bitonic_merger_top.sv
  - target: test
    files:
      - sim/merger_assertions.sv
      - sim/tb_bitonic_merger.sv

//--- sim/tb_bitonic_merger.sv
// tb_bitonic_merger: clock, reset, lfsr, stimulus table, wishbone bus tasks, compare tasks, watchdog.
`default_nettype none

module tb_bitonic_merger;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_ELEMS     = 8;
   localparam int HALF        = N_ELEMS / 2;
   localparam int N_ROWS      = 10;
   localparam int N_DIRECTED  = 4;
   localparam int ACK_LIMIT   = 16;
   localparam int WDOG_CYCLES = N_ROWS * 200 + 1000;
   localparam logic [31:0] LFSR_SEED = 32'h1514_92ce;

   logic                        i_clk;
   logic                        i_rst_n;
   logic                        wbi_cyc;
   logic                        wbi_stb;
   logic                        wbi_we;
   logic [merge_pkg::WB_AW-1:0] wbi_adr;
   logic [merge_pkg::WB_DW-1:0] wbi_dat_w;
   logic [merge_pkg::WB_DW-1:0] wbi_dat_r;
   logic                        wbi_ack;
   logic                        wbo_cyc;
   logic                        wbo_stb;
   logic                        wbo_we;
   logic [merge_pkg::WB_AW-1:0] wbo_adr;
   logic [merge_pkg::WB_DW-1:0] wbo_dat_w;
   logic [merge_pkg::WB_DW-1:0] wbo_dat_r;
   logic                        wbo_ack;

   // stimulus table, slots 0..3 hold run a and slots 4..7 hold run b.
   logic                        row_rand [N_ROWS];
   logic [merge_pkg::KEY_W-1:0] row_keys [N_ROWS][N_ELEMS];
   logic [merge_pkg::KEY_W-1:0] row_exp  [N_ROWS][N_ELEMS];
   logic [merge_pkg::TAG_W-1:0] row_tags [N_ROWS][N_ELEMS];
   logic [31:0]                 lfsr;

   bitonic_merger_top #(.N_ELEMS(N_ELEMS)) dut0 (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_wbi_cyc (wbi_cyc),
      .i_wbi_stb (wbi_stb),
      .i_wbi_we  (wbi_we),
      .i_wbi_adr (wbi_adr),
      .i_wbi_dat (wbi_dat_w),
      .o_wbi_dat (wbi_dat_r),
      .o_wbi_ack (wbi_ack),
      .i_wbo_cyc (wbo_cyc),
      .i_wbo_stb (wbo_stb),
      .i_wbo_we  (wbo_we),
      .i_wbo_adr (wbo_adr),
      .i_wbo_dat (wbo_dat_w),
      .o_wbo_dat (wbo_dat_r),
      .o_wbo_ack (wbo_ack)
   );

   initial i_clk = 1'b0;
   always #20 i_clk = ~i_clk;   // 40 ns period.

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1, "stopped at first error");
   endtask

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) n = n ^ 32'hD000_0001;
      return n;
   endfunction

   // one lfsr step per bit taken.
   task automatic draw_bits(input int nbits, output logic [15:0] v);
      v = '0;
      for (int b = 0; b < nbits; b++) begin
         v = {v[14:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   // insertion sort of k[lo..hi-1] by key.
   task automatic sort_keys(inout logic [merge_pkg::KEY_W-1:0] k [N_ELEMS],
                            input int lo, input int hi);
      logic [merge_pkg::KEY_W-1:0] t;
      int                          j;
      for (int i = lo + 1; i < hi; i++) begin
         t = k[i];
         j = i - 1;
         while (j >= lo && k[j] > t) begin
            k[j+1] = k[j];
            j--;
         end
         k[j+1] = t;
      end
   endtask

   task automatic build_table();
      logic [merge_pkg::KEY_W-1:0] k [N_ELEMS];
      logic [15:0]                 v;
      logic                        dup;
      // interleaved runs.
      row_keys[0] = '{16'h0100, 16'h0300, 16'h0500, 16'h0700,
                      16'h0200, 16'h0400, 16'h0600, 16'h0800};
      row_exp[0]  = '{16'h0100, 16'h0200, 16'h0300, 16'h0400,
                      16'h0500, 16'h0600, 16'h0700, 16'h0800};
      // run a wholly below run b.
      row_keys[1] = '{16'h0011, 16'h0022, 16'h0033, 16'h0044,
                      16'h1000, 16'h2000, 16'h3000, 16'h4000};
      row_exp[1]  = row_keys[1];
      // run b wholly below run a.
      row_keys[2] = '{16'h9000, 16'hA000, 16'hB000, 16'hC000,
                      16'h0005, 16'h0006, 16'h0007, 16'h0008};
      row_exp[2]  = '{16'h0005, 16'h0006, 16'h0007, 16'h0008,
                      16'h9000, 16'hA000, 16'hB000, 16'hC000};
      row_keys[3] = '{16'h0001, 16'h0002, 16'h8000, 16'hFFFF,
                      16'h0003, 16'h7FFF, 16'h8001, 16'hFFFE};
      row_exp[3]  = '{16'h0001, 16'h0002, 16'h0003, 16'h7FFF,
                      16'h8000, 16'h8001, 16'hFFFE, 16'hFFFF};
      for (int r = 0; r < N_ROWS; r++) begin
         row_rand[r] = (r >= N_DIRECTED);
         if (row_rand[r]) begin
            for (int i = 0; i < N_ELEMS; i++) begin
               dup = 1'b1;
               while (dup) begin   // redraw until the key is new.
                  draw_bits(merge_pkg::KEY_W, v);
                  dup = 1'b0;
                  for (int j = 0; j < i; j++) begin
                     if (k[j] == v) dup = 1'b1;
                  end
               end
               k[i] = v;
            end
            sort_keys(k, 0, HALF);
            sort_keys(k, HALF, N_ELEMS);
            row_keys[r] = k;
            sort_keys(k, 0, N_ELEMS);
            row_exp[r] = k;
         end
         for (int i = 0; i < N_ELEMS; i++) begin
            draw_bits(merge_pkg::TAG_W, v);
            row_tags[r][i] = v[merge_pkg::TAG_W-1:0];
         end
      end
   endtask

   function automatic merge_pkg::elem_t expected_elem(input int r, input int i);
      merge_pkg::elem_t e;
      e.key = row_exp[r][i];
      e.tag = '0;
      for (int s = 0; s < N_ELEMS; s++) begin
         if (row_keys[r][s] == e.key) e.tag = row_tags[r][s];   // tag follows its key.
      end
      return e;
   endfunction

   task automatic check_elem(input string name, input merge_pkg::elem_t exp,
                             input merge_pkg::elem_t act);
      if (act !== exp) begin
         abort_run($sformatf("[ERROR] %s: expected 0x%h, actual 0x%h", name, exp, act));
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         abort_run($sformatf("[ERROR] %s: expected 0x%h, actual 0x%h", name, exp, act));
      end
   endtask

   // out_side selects the wbo port, else wbi.
   task automatic wb_access(input logic out_side, input logic we,
                            input logic [merge_pkg::WB_AW-1:0] adr,
                            input logic [merge_pkg::WB_DW-1:0] wdat,
                            output logic [merge_pkg::WB_DW-1:0] rdat);
      int waited;
      waited = 0;
      @(negedge i_clk);
      if (out_side) begin
         wbo_cyc   = 1'b1;
         wbo_stb   = 1'b1;
         wbo_we    = we;
         wbo_adr   = adr;
         wbo_dat_w = wdat;
      end else begin
         wbi_cyc   = 1'b1;
         wbi_stb   = 1'b1;
         wbi_we    = we;
         wbi_adr   = adr;
         wbi_dat_w = wdat;
      end
      @(negedge i_clk);
      while (!(out_side ? wbo_ack : wbi_ack)) begin
         waited++;
         if (waited > ACK_LIMIT) begin
            abort_run($sformatf("no ack on the %s port within %0d cycles",
                                out_side ? "wbo" : "wbi", ACK_LIMIT));
         end
         @(negedge i_clk);
      end
      rdat = out_side ? wbo_dat_r : wbi_dat_r;
      wbo_cyc = 1'b0;
      wbo_stb = 1'b0;
      wbo_we  = 1'b0;
      wbi_cyc = 1'b0;
      wbi_stb = 1'b0;
      wbi_we  = 1'b0;
   endtask

   task automatic wb_write(input logic out_side, input logic [merge_pkg::WB_AW-1:0] adr,
                           input logic [merge_pkg::WB_DW-1:0] dat);
      logic [merge_pkg::WB_DW-1:0] unused;
      wb_access(out_side, 1'b1, adr, dat, unused);
   endtask

   task automatic wb_read(input logic out_side, input logic [merge_pkg::WB_AW-1:0] adr,
                          output logic [merge_pkg::WB_DW-1:0] dat);
      wb_access(out_side, 1'b0, adr, '0, dat);
   endtask

   // poll the status word until bit 0 equals want.
   task automatic wait_status(input logic out_side, input logic want, input int max_polls);
      logic [merge_pkg::WB_DW-1:0] d;
      int                          polls;
      polls = 0;
      wb_read(out_side, merge_pkg::CTRL_ADDR, d);
      while (d[0] !== want) begin
         polls++;
         if (polls > max_polls) begin
            abort_run($sformatf("%s status bit never became %0d after %0d polls",
                                out_side ? "wbo" : "wbi", want, max_polls));
         end
         wb_read(out_side, merge_pkg::CTRL_ADDR, d);
      end
   endtask

   task automatic write_slots(input int r);
      merge_pkg::elem_t e;
      for (int i = 0; i < N_ELEMS; i++) begin
         e.key = row_keys[r][i];
         e.tag = row_tags[r][i];
         wb_write(1'b0, merge_pkg::WB_AW'(i), merge_pkg::WB_DW'(e));
      end
   endtask

   task automatic load_row(input int r);
      wait_status(1'b0, 1'b0, 40);   // loader must be idle or writes are dropped.
      write_slots(r);
   endtask

   task automatic start_batch();
      wb_write(1'b0, merge_pkg::CTRL_ADDR, merge_pkg::WB_DW'(merge_pkg::CMD_START));
   endtask

   task automatic pop_result();
      wb_write(1'b1, merge_pkg::CTRL_ADDR, merge_pkg::WB_DW'(merge_pkg::CMD_POP));
   endtask

   task automatic check_row(input int r);
      logic [merge_pkg::WB_DW-1:0] d;
      for (int i = 0; i < N_ELEMS; i++) begin
         wb_read(1'b1, merge_pkg::WB_AW'(i), d);
         check_elem($sformatf("row %0d wbo slot %0d", r, i), expected_elem(r, i),
                    merge_pkg::elem_t'(d[merge_pkg::ELEM_W-1:0]));
      end
   endtask

   task automatic expect_status(input logic out_side, input logic want, input string name);
      logic [merge_pkg::WB_DW-1:0] d;
      wb_read(out_side, merge_pkg::CTRL_ADDR, d);
      check_flag(name, want, d[0]);
   endtask

   initial begin
      wbi_cyc   = 1'b0;
      wbi_stb   = 1'b0;
      wbi_we    = 1'b0;
      wbi_adr   = '0;
      wbi_dat_w = '0;
      wbo_cyc   = 1'b0;
      wbo_stb   = 1'b0;
      wbo_we    = 1'b0;
      wbo_adr   = '0;
      wbo_dat_w = '0;
      i_rst_n   = 1'b0;
      lfsr      = LFSR_SEED;
      build_table();
      repeat (4) @(posedge i_clk);
      @(negedge i_clk);
      i_rst_n = 1'b1;

      expect_status(1'b0, 1'b0, "wbi pending after reset");
      expect_status(1'b1, 1'b0, "wbo full after reset");

      for (int r = 0; r < N_ROWS; r++) begin
         load_row(r);
         start_batch();
         wait_status(1'b1, 1'b1, 40);
         check_row(r);
         pop_result();
         expect_status(1'b1, 1'b0, "wbo full after pop");
      end

      // two batches without a pop, the second waits behind the stall.
      load_row(0);
      start_batch();
      load_row(1);
      start_batch();
      wait_status(1'b1, 1'b1, 40);
      repeat (3) expect_status(1'b1, 1'b1, "wbo full while unread");
      expect_status(1'b0, 1'b1, "wbi pending under stall");
      check_row(0);
      pop_result();
      wait_status(1'b1, 1'b1, 40);
      check_row(1);
      pop_result();

      // repeated start and slot writes while pending.
      load_row(2);
      start_batch();
      wait_status(1'b1, 1'b1, 40);
      load_row(3);
      start_batch();
      start_batch();
      write_slots(4);
      expect_status(1'b0, 1'b1, "wbi pending after repeated start");
      check_row(2);
      pop_result();
      wait_status(1'b1, 1'b1, 40);
      check_row(3);
      pop_result();
      repeat (10) expect_status(1'b1, 1'b0, "wbo full with nothing launched");   // ~20 cycles.

      if (dut0.chk0.fail_count == 0) begin
         $display("Testbench passed");
         $finish;
      end else begin
         abort_run("a bound assertion on the DUT ports failed");
      end
   end

   always @(negedge i_clk) begin
      if (dut0.chk0.fail_count != 0) abort_run("a bound assertion on the DUT ports failed");
   end

   initial begin
      repeat (WDOG_CYCLES) @(posedge i_clk);
      abort_run($sformatf("the run timed out after %0d cycles", WDOG_CYCLES));
   end

endmodule

`default_nettype wire

//--- sim/merger_assertions.sv
// wishbone handshake and stall rules on the merger top level, with the bind.
`default_nettype none

module merger_assertions #(
   parameter int N_ELEMS = 8
) (
   input logic                           i_clk,
   input logic                           i_rst_n,
   input logic                           i_wbi_stb,
   input logic                           i_wbi_ack,
   input logic                           i_wbo_stb,
   input logic                           i_wbo_ack,
   input logic                           i_stall,
   input merge_pkg::elem_t [N_ELEMS-1:0] i_batch,
   input logic                           i_launch
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_count = 0;

   // ack rises one cycle after a request.
   a_wbi_ack_stb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $rose(i_wbi_ack) |-> $past(i_wbi_stb))
      else begin
         fail_count++;
         $error("wbi ack rose without stb");
      end

   a_wbo_ack_stb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $rose(i_wbo_ack) |-> $past(i_wbo_stb))
      else begin
         fail_count++;
         $error("wbo ack rose without stb");
      end

   a_wbi_ack_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_wbi_ack |=> !i_wbi_ack)
      else begin
         fail_count++;
         $error("wbi ack longer than one cycle");
      end

   a_wbo_ack_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_wbo_ack |=> !i_wbo_ack)
      else begin
         fail_count++;
         $error("wbo ack longer than one cycle");
      end

   // loader output holds while the pipeline is stalled.
   a_no_launch_stalled: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_stall |=> $stable(i_batch) && $stable(i_launch))
      else begin
         fail_count++;
         $error("loader launched while stalled");
      end

endmodule

bind bitonic_merger_top merger_assertions #(.N_ELEMS(N_ELEMS)) chk0 (
   .i_clk     (i_clk),
   .i_rst_n   (i_rst_n),
   .i_wbi_stb (i_wbi_stb),
   .i_wbi_ack (o_wbi_ack),
   .i_wbo_stb (i_wbo_stb),
   .i_wbo_ack (o_wbo_ack),
   .i_stall   (stall),
   .i_batch   (stg_batch[0]),
   .i_launch  (stg_valid[0])
);

`default_nettype wire

//--- source/bitonic_merger_top.sv
// bitonic_merger_top: loader, generated merge stages and collector.
`default_nettype none

module bitonic_merger_top #(
   parameter int N_ELEMS = 8
) (
   input  logic                        i_clk,
   input  logic                        i_rst_n,
   // input side port.
   input  logic                        i_wbi_cyc,
   input  logic                        i_wbi_stb,
   input  logic                        i_wbi_we,
   input  logic [merge_pkg::WB_AW-1:0] i_wbi_adr,
   input  logic [merge_pkg::WB_DW-1:0] i_wbi_dat,
   output logic [merge_pkg::WB_DW-1:0] o_wbi_dat,
   output logic                        o_wbi_ack,
   // output side port.
   input  logic                        i_wbo_cyc,
   input  logic                        i_wbo_stb,
   input  logic                        i_wbo_we,
   input  logic [merge_pkg::WB_AW-1:0] i_wbo_adr,
   input  logic [merge_pkg::WB_DW-1:0] i_wbo_dat,
   output logic [merge_pkg::WB_DW-1:0] o_wbo_dat,
   output logic                        o_wbo_ack
);

   localparam int N_STAGES = $clog2(N_ELEMS);

   // index 0 is the loader output, index N_STAGES feeds the collector.
   merge_pkg::elem_t [N_ELEMS-1:0] stg_batch [N_STAGES+1];
   logic [N_STAGES:0]              stg_valid;
   logic                           stall;

   merge_loader #(.N_ELEMS(N_ELEMS)) loader0 (
      .i_clk    (i_clk),
      .i_rst_n  (i_rst_n),
      .i_wb_cyc (i_wbi_cyc),
      .i_wb_stb (i_wbi_stb),
      .i_wb_we  (i_wbi_we),
      .i_wb_adr (i_wbi_adr),
      .i_wb_dat (i_wbi_dat),
      .o_wb_dat (o_wbi_dat),
      .o_wb_ack (o_wbi_ack),
      .i_stall  (stall),
      .o_batch  (stg_batch[0]),
      .o_valid  (stg_valid[0])
   );

   for (genvar k = 0; k < N_STAGES; k++) begin : g_stage
      merge_stage #(.N_ELEMS(N_ELEMS), .STAGE(k)) stage (
         .i_clk   (i_clk),
         .i_rst_n (i_rst_n),
         .i_stall (stall),
         .i_batch (stg_batch[k]),
         .i_valid (stg_valid[k]),
         .o_batch (stg_batch[k+1]),
         .o_valid (stg_valid[k+1])
      );
   end

   merge_collector #(.N_ELEMS(N_ELEMS)) collector0 (
      .i_clk    (i_clk),
      .i_rst_n  (i_rst_n),
      .i_batch  (stg_batch[N_STAGES]),
      .i_valid  (stg_valid[N_STAGES]),
      .i_wb_cyc (i_wbo_cyc),
      .i_wb_stb (i_wbo_stb),
      .i_wb_we  (i_wbo_we),
      .i_wb_adr (i_wbo_adr),
      .i_wb_dat (i_wbo_dat),
      .o_wb_dat (o_wbo_dat),
      .o_wb_ack (o_wbo_ack),
      .o_stall  (stall)
   );

endmodule

`default_nettype wire

//--- source/merge_collector.sv
// merge_collector: result buffer, full flag and stall, output side wishbone slave.
`default_nettype none

module merge_collector #(
   parameter int N_ELEMS = 8
) (
   input  logic                                  i_clk,
   input  logic                                  i_rst_n,
   input  merge_pkg::elem_t [N_ELEMS-1:0]        i_batch,
   input  logic                                  i_valid,
   input  logic                                  i_wb_cyc,
   input  logic                                  i_wb_stb,
   input  logic                                  i_wb_we,
   input  logic [merge_pkg::WB_AW-1:0]           i_wb_adr,
   input  logic [merge_pkg::WB_DW-1:0]           i_wb_dat,
   output logic [merge_pkg::WB_DW-1:0]           o_wb_dat,
   output logic                                  o_wb_ack,
   output logic                                  o_stall
);

   merge_pkg::elem_t [N_ELEMS-1:0] result;
   merge_pkg::cmd_e                cmd;
   logic                           wb_req;
   logic                           is_ctrl;
   logic                           is_slot;
   logic                           capture;
   logic                           pop_req;
   logic                           full;

   assign wb_req  = i_wb_cyc & i_wb_stb & ~o_wb_ack;
   assign is_ctrl = (i_wb_adr == merge_pkg::CTRL_ADDR);
   assign is_slot = !is_ctrl && (i_wb_adr < N_ELEMS);
   assign cmd     = merge_pkg::cmd_e'(i_wb_dat[1:0]);
   assign pop_req = wb_req & i_wb_we & is_ctrl & (cmd == merge_pkg::CMD_POP);

   // pipeline is frozen while full, so a batch waits at the last stage.
   assign capture = i_valid & ~full;

   // single result buffer, so full is the stall.
   assign o_stall = full;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_wb_ack <= 1'b0;
         full     <= 1'b0;
      end else begin
         o_wb_ack <= wb_req;
         if (capture) begin
            full <= 1'b1;
         end else if (pop_req) begin
            full <= 1'b0;   // stall drops on the next cycle.
         end
      end
   end

   // result buffer and read data.
   always_ff @(posedge i_clk) begin
      if (capture) begin
         result <= i_batch;
      end
      if (wb_req && !i_wb_we) begin
         if (is_ctrl) begin
            o_wb_dat <= {{(merge_pkg::WB_DW-1){1'b0}}, full};
         end else if (is_slot) begin
            o_wb_dat <= {{(merge_pkg::WB_DW-merge_pkg::ELEM_W){1'b0}}, result[i_wb_adr]};
         end else begin
            o_wb_dat <= '0;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/merge_stage.sv
// one stallable compare-exchange level of the bitonic merge.
`default_nettype none

module merge_stage #(
   parameter int N_ELEMS = 8,
   parameter int STAGE   = 0
) (
   input  logic                           i_clk,
   input  logic                           i_rst_n,
   input  logic                           i_stall,
   input  merge_pkg::elem_t [N_ELEMS-1:0] i_batch,
   input  logic                           i_valid,
   output merge_pkg::elem_t [N_ELEMS-1:0] o_batch,
   output logic                           o_valid
);

   // pair distance halves with each stage.
   localparam int DIST = N_ELEMS >> (STAGE + 1);

   // partner index is lo xor mask.
   // stage 0 mirrors (N-1-lo), later stages step by DIST inside 2*DIST blocks.
   localparam int PAIR_MASK = (STAGE == 0) ? (N_ELEMS - 1) : DIST;

   merge_pkg::elem_t [N_ELEMS-1:0] nxt_batch;

   // compare-exchange network for this level.
   always_comb begin
      nxt_batch = i_batch;
      for (int lo = 0; lo < N_ELEMS; lo++) begin
         // lower member of each pair has the DIST bit clear.
         if ((lo & DIST) == 0) begin
            // strict compare so equal keys stay put.
            if (i_batch[lo].key > i_batch[lo ^ PAIR_MASK].key) begin
               nxt_batch[lo]             = i_batch[lo ^ PAIR_MASK];
               nxt_batch[lo ^ PAIR_MASK] = i_batch[lo];
            end
         end
      end
   end

   // valid bit travels with the data.
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_valid <= 1'b0;
      end else if (!i_stall) begin
         o_valid <= i_valid;
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_stall) o_batch <= nxt_batch;   // frozen under stall.
   end

endmodule

`default_nettype wire

//--- source/merge_loader.sv
// merge_loader: input side wishbone slave, element slots and batch launch.
`default_nettype none

module merge_loader #(
   parameter int N_ELEMS = 8
) (
   input  logic                                  i_clk,
   input  logic                                  i_rst_n,
   input  logic                                  i_wb_cyc,
   input  logic                                  i_wb_stb,
   input  logic                                  i_wb_we,
   input  logic [merge_pkg::WB_AW-1:0]           i_wb_adr,
   input  logic [merge_pkg::WB_DW-1:0]           i_wb_dat,
   output logic [merge_pkg::WB_DW-1:0]           o_wb_dat,
   output logic                                  o_wb_ack,
   input  logic                                  i_stall,
   output merge_pkg::elem_t [N_ELEMS-1:0]        o_batch,
   output logic                                  o_valid
);

   merge_pkg::elem_t [N_ELEMS-1:0] slots;
   merge_pkg::cmd_e                cmd;
   logic                           wb_req;
   logic                           is_ctrl;
   logic                           is_slot;
   logic                           start_req;
   logic                           launch;
   logic                           pending;

   // new request only, the held cycle after ack is not a second access.
   assign wb_req    = i_wb_cyc & i_wb_stb & ~o_wb_ack;
   // ctrl word wins over the top slot when N_ELEMS is 16.
   assign is_ctrl   = (i_wb_adr == merge_pkg::CTRL_ADDR);
   assign is_slot   = !is_ctrl && (i_wb_adr < N_ELEMS);
   assign cmd       = merge_pkg::cmd_e'(i_wb_dat[1:0]);
   assign start_req = wb_req & i_wb_we & is_ctrl & (cmd == merge_pkg::CMD_START);
   assign launch    = pending & ~i_stall;

   // ack, pending flag and launch valid.
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_wb_ack <= 1'b0;
         pending  <= 1'b0;
         o_valid  <= 1'b0;
      end else begin
         o_wb_ack <= wb_req;
         if (pending) begin
            if (!i_stall) pending <= 1'b0;   // a second start is dropped.
         end else if (start_req) begin
            pending <= 1'b1;
         end
         // valid holds under stall like every stage register.
         if (!i_stall) o_valid <= pending;
      end
   end

   // slots, launched batch and read data.
   always_ff @(posedge i_clk) begin
      if (wb_req && i_wb_we && is_slot && !pending) begin
         slots[i_wb_adr] <= merge_pkg::elem_t'(i_wb_dat[merge_pkg::ELEM_W-1:0]);
      end
      if (launch) begin
         o_batch <= slots;
      end
      if (wb_req && !i_wb_we) begin
         if (is_ctrl) begin
            o_wb_dat <= {{(merge_pkg::WB_DW-1){1'b0}}, pending};
         end else if (is_slot) begin
            o_wb_dat <= {{(merge_pkg::WB_DW-merge_pkg::ELEM_W){1'b0}}, slots[i_wb_adr]};
         end else begin
            o_wb_dat <= '0;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/merge_pkg.sv
// merge_pkg: element struct, command enum, register index and bus widths.
`default_nettype none

package merge_pkg;

   // element layout.
   localparam int KEY_W = 16;
   localparam int TAG_W = 8;

   // key sits above the tag, so the key lands in bits 23:8 of a bus word.
   typedef struct packed {
      logic [KEY_W-1:0] key;
      logic [TAG_W-1:0] tag;
   } elem_t;

   localparam int ELEM_W = $bits(elem_t);

   // wishbone widths, word addressed.
   localparam int WB_DW = 32;
   localparam int WB_AW = 4;

   // control/status word, same index on both ports.
   // slots use indices 0 to N_ELEMS-1 below it.
   localparam logic [WB_AW-1:0] CTRL_ADDR = 4'd15;

   // commands go in bits 1:0 of a write to CTRL_ADDR.
   typedef enum logic [1:0] {
      CMD_NOP   = 2'd0,
      CMD_START = 2'd1,   // loader only.
      CMD_POP   = 2'd2    // collector only.
   } cmd_e;

endpackage

`default_nettype wire
